// File: src/radio_cfg_pkg.sv
package radio_cfg_pkg;

  // ------------------------------
  // Host command bus
  // ------------------------------

  // One host register write
  typedef struct packed {
    logic [5:0]  addr;
    logic [31:0] data;
    logic        rqst;
  } cmd_req_t;

  // Command addresses
  localparam logic [5:0] CMD_CTRL      = 6'h00;
  localparam logic [5:0] CMD_TX_FREQ   = 6'h01;
  localparam logic [5:0] CMD_RX0_FREQ  = 6'h02;
  localparam logic [5:0] CMD_VNA       = 6'h09;
  localparam logic [5:0] CMD_CW_HANG   = 6'h10;
  localparam logic [5:0] CMD_TX_TIMING = 6'h17;

  // ------------------------------
  // Keyer timing settings
  // ------------------------------

  // Latency and PTT hang in ms, CW hang in host units
  typedef struct packed {
    logic [4:0] buf_latency;
    logic [4:0] ptt_hang;
    logic [9:0] cw_hang;
  } tx_timing_t;

  // 10 ms latency, 4 ms PTT hang, no CW hang
  localparam tx_timing_t TX_TIMING_RST = '{buf_latency: 5'd10, ptt_hang: 5'd4, cw_hang: 10'd0};

  // ------------------------------
  // NCO frequency words
  // ------------------------------

  // Phase increment per clock
  typedef logic [31:0] phase_t;

  // Scale factor 2^57 / clock, trimmed per board oscillator
  function automatic logic [31:0] freq_mult(input int clk_freq);
    case (clk_freq)
      61440000: return 32'd2345640077;
      79872000: return 32'd1804326773;
      76800000: return 32'd1876499845;
      default:  return 32'd1954687338;
    endcase
  endfunction

  // Rounding term, half an LSB of the kept slice
  localparam logic [31:0] FREQ_ROUND = 32'd16777216;

endpackage

// File: src/radio_tx_pkg.sv
package radio_tx_pkg;

  // ------------------------------
  // Keying states
  // ------------------------------

  // Encodings kept from the legacy keyer
  typedef enum logic [2:0] {
    NOTX   = 3'b000,
    PRETX  = 3'b001,
    PTTTX  = 3'b011,
    CWTX   = 3'b101,
    CWHANG = 3'b100
  } tx_state_e;

  // ------------------------------
  // Baseband samples
  // ------------------------------

  // One complex sample for the NCO
  typedef struct packed {
    logic signed [15:0] i;
    logic signed [15:0] q;
  } iq_sample_t;

  // Host TX stream, I in tdata high half
  typedef struct packed {
    logic [31:0] tdata;
    logic        tvalid;
    logic [3:0]  tuser;
  } tx_stream_t;

  // tuser flag positions
  localparam int TUSER_CWX = 2;
  localparam int TUSER_PTT = 3;

  // Keyer state seen by the baseband stage
  typedef struct packed {
    tx_state_e   state;
    logic [18:0] cw_level;
    logic        load;
  } key_status_t;

  // Full CW drive, VNA_TONE with four fraction bits
  localparam logic [18:0] CW_LEVEL_MAX = 19'h4d800;
  // Fixed VNA carrier level
  localparam logic [15:0] VNA_TONE     = 16'h4d80;

endpackage

// File: src/radio_cmd_decoder.sv
`timescale 1ns/1ps

module radio_cmd_decoder #(
  parameter int CLK_FREQ = 76800000
) (
  input  logic                      clk,
  input  logic                      rst_all,
  input  radio_cfg_pkg::cmd_req_t   cmd_i,
  output logic                      cmd_ack_o,
  output radio_cfg_pkg::tx_timing_t timing_o,
  output logic                      vna_o,
  output radio_cfg_pkg::phase_t     tx_phase_o,
  output radio_cfg_pkg::phase_t     rx0_phase_o
);

  // Multiplier for the build clock
  localparam logic [31:0] FREQ_MULT = radio_cfg_pkg::freq_mult(CLK_FREQ);

  typedef enum logic [1:0] {
    CMD_IDLE  = 2'b00,
    CMD_FREQ1 = 2'b01,
    CMD_FREQ2 = 2'b11,
    CMD_FREQ3 = 2'b10
  } cmd_state_e;

  cmd_state_e            cmd_state;
  cmd_state_e            cmd_state_next;
  logic                  duplex;
  logic                  freq_req;
  logic                  reg_write;
  logic [63:0]           freq_comp;
  radio_cfg_pkg::phase_t freq_word;
  logic                  freq_is_tx;

  // ------------------------------
  // Command FSM
  // ------------------------------

  // Only TX and RX0 frequencies remain
  assign freq_req = cmd_i.rqst &&
                    (cmd_i.addr == radio_cfg_pkg::CMD_TX_FREQ ||
                     cmd_i.addr == radio_cfg_pkg::CMD_RX0_FREQ);

  // Plain register writes land straight from idle
  assign reg_write = cmd_i.rqst && (cmd_state == CMD_IDLE);

  always_ff @(posedge clk) begin
    if (rst_all) begin
      cmd_state <= CMD_IDLE;
    end else begin
      cmd_state <= cmd_state_next;
    end
  end

  always_comb begin
    cmd_state_next = cmd_state;
    cmd_ack_o      = 1'b0;
    case (cmd_state)
      CMD_IDLE: begin
        if (freq_req) begin
          cmd_state_next = CMD_FREQ1;
        end
      end
      // Two cycles for the wide multiply
      CMD_FREQ1: cmd_state_next = CMD_FREQ2;
      CMD_FREQ2: cmd_state_next = CMD_FREQ3;
      // Ack while the phase registers load
      CMD_FREQ3: begin
        cmd_state_next = CMD_IDLE;
        cmd_ack_o      = 1'b1;
      end
      default: cmd_state_next = CMD_IDLE;
    endcase
  end

  // ------------------------------
  // Configuration registers
  // ------------------------------

  always_ff @(posedge clk) begin
    if (rst_all) begin
      vna_o    <= 1'b0;
      duplex   <= 1'b0;
      timing_o <= radio_cfg_pkg::TX_TIMING_RST;
    end else if (reg_write) begin
      case (cmd_i.addr)
        radio_cfg_pkg::CMD_CTRL: duplex <= cmd_i.data[2];
        radio_cfg_pkg::CMD_VNA:  vna_o  <= cmd_i.data[23];
        // Hang time split across two byte lanes
        radio_cfg_pkg::CMD_CW_HANG: begin
          timing_o.cw_hang <= {cmd_i.data[31:24], cmd_i.data[17:16]};
        end
        radio_cfg_pkg::CMD_TX_TIMING: begin
          timing_o.buf_latency <= cmd_i.data[4:0];
          timing_o.ptt_hang    <= cmd_i.data[12:8];
        end
        default: ;
      endcase
    end
  end

  // ------------------------------
  // Frequency pipeline
  // ------------------------------

  // Host holds data until ack, so compute continuously
  assign freq_comp = {32'd0, cmd_i.data} * {32'd0, FREQ_MULT} +
                     {32'd0, radio_cfg_pkg::FREQ_ROUND};

  // Capture product and target after the settle cycle
  always_ff @(posedge clk) begin
    if (cmd_state == CMD_FREQ2) begin
      freq_word  <= freq_comp[56:25];
      freq_is_tx <= (cmd_i.addr == radio_cfg_pkg::CMD_TX_FREQ);
    end
  end

  // Phase words with the duplex rule
  always_ff @(posedge clk) begin
    if (rst_all) begin
      tx_phase_o  <= '0;
      rx0_phase_o <= '0;
    end else if (cmd_state == CMD_FREQ3) begin
      if (freq_is_tx) begin
        tx_phase_o <= freq_word;
        // Simplex RX follows TX
        if (!duplex) begin
          rx0_phase_o <= freq_word;
        end
      end else if (!duplex) begin
        rx0_phase_o <= tx_phase_o;
      end else begin
        rx0_phase_o <= freq_word;
      end
    end
  end

endmodule

// File: src/tx_keyer.sv
`timescale 1ns/1ps

module tx_keyer (
  input  logic                      clk,
  input  logic                      rst_all,
  input  logic                      run_i,
  input  logic                      qmsec_pulse_i,
  input  logic                      ext_keydown_i,
  input  logic                      sample_req_i,
  input  radio_tx_pkg::tx_stream_t  tx_stream_i,
  input  radio_cfg_pkg::tx_timing_t timing_i,
  output logic                      tx_on_o,
  output logic                      cw_on_o,
  output logic                      tx_tready_o,
  output radio_tx_pkg::key_status_t key_o
);

  radio_tx_pkg::tx_state_e state;
  radio_tx_pkg::tx_state_e state_next;
  logic [6:0]              qmsec_timer;
  logic [6:0]              qmsec_timer_next;
  logic [18:0]             cw_level;
  logic [18:0]             cw_level_next;
  logic                    cwx;
  logic                    ptt;
  logic                    cw_key;
  logic                    key_down;
  logic                    timer_done;
  logic                    load;
  logic [6:0]              latency_ticks;
  logic [6:0]              ptt_hang_ticks;
  logic [18:0]             cw_hang_level;

  // ------------------------------
  // Key sources
  // ------------------------------

  // Stream flags count only with valid data
  assign cwx      = tx_stream_i.tuser[radio_tx_pkg::TUSER_CWX] & tx_stream_i.tvalid;
  assign ptt      = tx_stream_i.tuser[radio_tx_pkg::TUSER_PTT] & tx_stream_i.tvalid;
  assign cw_key   = ext_keydown_i | cwx;
  assign key_down = cw_key | ptt;

  // Millisecond settings in qmsec ticks
  assign latency_ticks  = {timing_i.buf_latency, 2'b00};
  assign ptt_hang_ticks = {timing_i.ptt_hang, 2'b00};
  assign cw_hang_level  = {7'd0, timing_i.cw_hang, 2'b00};

  assign timer_done = (qmsec_timer == 7'd0);

  // ------------------------------
  // State registers
  // ------------------------------

  always_ff @(posedge clk) begin
    if (rst_all) begin
      state       <= radio_tx_pkg::NOTX;
      qmsec_timer <= 7'd0;
      cw_level    <= 19'd0;
    end else begin
      // Run low drops straight to receive
      state       <= run_i ? state_next : radio_tx_pkg::NOTX;
      qmsec_timer <= qmsec_timer_next;
      cw_level    <= cw_level_next;
    end
  end

  // ------------------------------
  // Keying FSM
  // ------------------------------

  always_comb begin
    state_next       = state;
    qmsec_timer_next = qmsec_timer;
    cw_level_next    = cw_level;
    load             = 1'b0;

    case (state)
      radio_tx_pkg::NOTX: begin
        cw_level_next    = 19'd0;
        qmsec_timer_next = latency_ticks;
        if (key_down) begin
          state_next = radio_tx_pkg::PRETX;
        end
      end

      // Let the host buffer fill before keying
      radio_tx_pkg::PRETX: begin
        if (!timer_done) begin
          if (qmsec_pulse_i) begin
            qmsec_timer_next = qmsec_timer - 7'd1;
          end
          if (!key_down) begin
            state_next = radio_tx_pkg::NOTX;
          end
        end else if (cw_key) begin
          state_next = radio_tx_pkg::CWTX;
        end else begin
          state_next = radio_tx_pkg::PTTTX;
        end
      end

      radio_tx_pkg::PTTTX: begin
        if (ext_keydown_i) begin
          state_next = radio_tx_pkg::CWTX;
        end else if (ptt) begin
          // Hang restarts on every PTT sample
          qmsec_timer_next = ptt_hang_ticks;
          load             = sample_req_i;
        end else if (!timer_done) begin
          if (qmsec_pulse_i) begin
            qmsec_timer_next = qmsec_timer - 7'd1;
          end
        end else begin
          state_next = radio_tx_pkg::NOTX;
        end
      end

      radio_tx_pkg::CWTX: begin
        if (cw_key) begin
          // Rising edge shaping, one step per clock
          if (cw_level != radio_tx_pkg::CW_LEVEL_MAX) begin
            cw_level_next = cw_level + 19'd1;
          end
          qmsec_timer_next = latency_ticks;
        end else if (!timer_done) begin
          // Delay release to match buffered audio
          if (qmsec_pulse_i) begin
            qmsec_timer_next = qmsec_timer - 7'd1;
          end
        end else if (cw_level != 19'd0) begin
          cw_level_next = cw_level - 19'd1;
        end else begin
          // Level register doubles as hang counter
          qmsec_timer_next = latency_ticks;
          cw_level_next    = cw_hang_level;
          state_next       = radio_tx_pkg::CWHANG;
        end
      end

      radio_tx_pkg::CWHANG: begin
        if (cw_key) begin
          if (!timer_done) begin
            if (qmsec_pulse_i) begin
              qmsec_timer_next = qmsec_timer - 7'd1;
            end
          end else begin
            qmsec_timer_next = latency_ticks;
            cw_level_next    = 19'd0;
            state_next       = radio_tx_pkg::CWTX;
          end
        end else if (cw_level != 19'd0) begin
          if (qmsec_pulse_i) begin
            cw_level_next = cw_level - 19'd1;
          end
        end else begin
          state_next = radio_tx_pkg::NOTX;
        end
      end

      default: state_next = radio_tx_pkg::NOTX;
    endcase
  end

  // ------------------------------
  // Outputs
  // ------------------------------

  assign tx_on_o = (state != radio_tx_pkg::NOTX);
  assign cw_on_o = (state == radio_tx_pkg::CWTX) || (state == radio_tx_pkg::CWHANG);

  // Stall the stream during prefill
  assign tx_tready_o = (state == radio_tx_pkg::PRETX) ? 1'b0 : sample_req_i;

  assign key_o = '{state: state, cw_level: cw_level, load: load};

endmodule

// File: src/tx_baseband.sv
`timescale 1ns/1ps

module tx_baseband (
  input  logic                      clk,
  input  logic                      rst_all,
  input  radio_tx_pkg::key_status_t key_i,
  input  radio_tx_pkg::iq_sample_t  tx_data_i,
  input  logic                      vna_i,
  output radio_tx_pkg::iq_sample_t  tx_iq_o
);

  radio_tx_pkg::iq_sample_t held;
  radio_tx_pkg::iq_sample_t iq_next;

  // ------------------------------
  // PTT sample hold
  // ------------------------------

  // Last accepted sample, silent when idle
  always_ff @(posedge clk) begin
    if (rst_all) begin
      held <= '0;
    end else if (key_i.state == radio_tx_pkg::NOTX) begin
      held <= '0;
    end else if (key_i.load) begin
      held <= tx_data_i;
    end
  end

  // ------------------------------
  // NCO source select
  // ------------------------------

  always_comb begin
    if (vna_i) begin
      // Constant carrier for VNA sweeps
      iq_next.i = radio_tx_pkg::VNA_TONE;
      iq_next.q = 16'sd0;
    end else if (key_i.state == radio_tx_pkg::CWTX) begin
      // Drop the fraction bits, keep I positive
      iq_next.i = {1'b0, key_i.cw_level[18:4]};
      iq_next.q = 16'sd0;
    end else begin
      iq_next = held;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_all) begin
      tx_iq_o <= '0;
    end else begin
      tx_iq_o <= iq_next;
    end
  end

endmodule

// File: src/radio_top.sv
`timescale 1ns/1ps

module radio_top #(
  parameter int CLK_FREQ = 76800000
) (
  input  logic                     clk,
  input  logic                     rst_all,
  input  logic                     run_i,
  input  logic                     qmsec_pulse_i,
  input  logic                     ext_keydown_i,
  input  logic                     sample_req_i,
  input  radio_cfg_pkg::cmd_req_t  cmd_i,
  input  radio_tx_pkg::tx_stream_t tx_stream_i,
  output logic                     cmd_ack_o,
  output logic                     tx_on_o,
  output logic                     cw_on_o,
  output logic                     tx_tready_o,
  output radio_tx_pkg::iq_sample_t tx_iq_o,
  output radio_cfg_pkg::phase_t    tx_phase_o,
  output radio_cfg_pkg::phase_t    rx0_phase_o
);

  radio_cfg_pkg::tx_timing_t timing;
  logic                      vna;
  radio_tx_pkg::key_status_t key_status;
  radio_tx_pkg::iq_sample_t  tx_data;

  // tdata halves as an I/Q pair
  assign tx_data = radio_tx_pkg::iq_sample_t'(tx_stream_i.tdata);

  // ------------------------------
  // Control and keying
  // ------------------------------

  radio_cmd_decoder #(
    .CLK_FREQ(CLK_FREQ)
  ) cmd_decoder_i (
    .clk        (clk),
    .rst_all    (rst_all),
    .cmd_i      (cmd_i),
    .cmd_ack_o  (cmd_ack_o),
    .timing_o   (timing),
    .vna_o      (vna),
    .tx_phase_o (tx_phase_o),
    .rx0_phase_o(rx0_phase_o)
  );

  tx_keyer keyer_i (
    .clk          (clk),
    .rst_all      (rst_all),
    .run_i        (run_i),
    .qmsec_pulse_i(qmsec_pulse_i),
    .ext_keydown_i(ext_keydown_i),
    .sample_req_i (sample_req_i),
    .tx_stream_i  (tx_stream_i),
    .timing_i     (timing),
    .tx_on_o      (tx_on_o),
    .cw_on_o      (cw_on_o),
    .tx_tready_o  (tx_tready_o),
    .key_o        (key_status)
  );

  // ------------------------------
  // Baseband to the TX NCO
  // ------------------------------

  tx_baseband baseband_i (
    .clk      (clk),
    .rst_all  (rst_all),
    .key_i    (key_status),
    .tx_data_i(tx_data),
    .vna_i    (vna),
    .tx_iq_o  (tx_iq_o)
  );

endmodule

// File: tb/radio_top_tb.sv
`timescale 1ns/1ps

module radio_top_tb;

  // Multiplier for the DUT default 76.8 MHz clock
  localparam logic [63:0] REF_MULT    = 64'd1876499845;
  localparam logic [63:0] REF_ROUND   = 64'd16777216;
  localparam int          WAIT_SHORT  = 2000;
  localparam int          WAIT_RAMP   = 400000;
  localparam int          LAT_MS      = 2;
  localparam int          PTT_HANG_MS = 1;
  localparam int          CW_HANG     = 2;
  localparam int          LEVEL_MAX   = int'(radio_tx_pkg::CW_LEVEL_MAX);

  logic                     clk;
  logic                     rst_all;
  logic                     run_i;
  logic                     qmsec_pulse_i = 1'b0;
  logic                     ext_keydown_i;
  logic                     sample_req_i;
  radio_cfg_pkg::cmd_req_t  cmd_i;
  radio_tx_pkg::tx_stream_t tx_stream_i;
  logic                     cmd_ack_o;
  logic                     tx_on_o;
  logic                     cw_on_o;
  logic                     tx_tready_o;
  radio_tx_pkg::iq_sample_t tx_iq_o;
  radio_cfg_pkg::phase_t    tx_phase_o;
  radio_cfg_pkg::phase_t    rx0_phase_o;

  logic [2:0]  qmsec_cnt = 3'd0;
  logic [31:0] rng_state = 32'h869a_f83a;
  int          checks = 0;
  int          errors = 0;
  int          tests = 0;
  int          failed_tests = 0;
  int          test_err_base = 0;

  radio_top radio_top_i (
    .clk          (clk),
    .rst_all      (rst_all),
    .run_i        (run_i),
    .qmsec_pulse_i(qmsec_pulse_i),
    .ext_keydown_i(ext_keydown_i),
    .sample_req_i (sample_req_i),
    .cmd_i        (cmd_i),
    .tx_stream_i  (tx_stream_i),
    .cmd_ack_o    (cmd_ack_o),
    .tx_on_o      (tx_on_o),
    .cw_on_o      (cw_on_o),
    .tx_tready_o  (tx_tready_o),
    .tx_iq_o      (tx_iq_o),
    .tx_phase_o   (tx_phase_o),
    .rx0_phase_o  (rx0_phase_o)
  );

  // ------------------------------
  // Clock and qmsec tick
  // ------------------------------

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // One pulse every 8 clocks
  always @(posedge clk) begin
    if (rst_all) begin
      qmsec_cnt     <= 3'd0;
      qmsec_pulse_i <= 1'b0;
    end else begin
      qmsec_cnt     <= qmsec_cnt + 3'd1;
      qmsec_pulse_i <= (qmsec_cnt == 3'd7);
    end
  end

  // ------------------------------
  // Reference functions
  // ------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] draw_random();
    rng_state = lcg_next(rng_state);
    return rng_state;
  endfunction

  // Bits 56..25 of product plus rounding term
  function automatic radio_cfg_pkg::phase_t ref_phase_word(input logic [31:0] data);
    logic [63:0] sum;
    sum = {32'd0, data} * REF_MULT + REF_ROUND;
    return sum[56:25];
  endfunction

  // I in the high half of tdata
  function automatic radio_tx_pkg::iq_sample_t ref_ptt_iq(input logic [31:0] data);
    radio_tx_pkg::iq_sample_t s;
    s.i = data[31:16];
    s.q = data[15:0];
    return s;
  endfunction

  function automatic radio_tx_pkg::iq_sample_t ref_cw_iq(input logic [18:0] level);
    radio_tx_pkg::iq_sample_t s;
    s.i = 16'(level >> 4);
    s.q = 16'sd0;
    return s;
  endfunction

  // ------------------------------
  // Compare and report
  // ------------------------------

  task automatic note_failure(input string msg);
    errors++;
    $display("FAIL at %0t ns: %s", $time, msg);
  endtask

  task automatic check_phase(input radio_cfg_pkg::phase_t got,
                             input radio_cfg_pkg::phase_t exp, input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t ns %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_iq(input radio_tx_pkg::iq_sample_t got,
                          input radio_tx_pkg::iq_sample_t exp, input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t ns %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t ns %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic begin_test();
    tests++;
    test_err_base = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == test_err_base) begin
      $display("Test %0d %s: ok", tests, name);
    end else begin
      failed_tests++;
      $display("Test %0d %s: %0d errors", tests, name, errors - test_err_base);
    end
  endtask

  // Ready follows the request in NOTX, CWTX and CWHANG
  always @(negedge clk) begin
    if (!rst_all && (!tx_on_o || cw_on_o)) begin
      check_bit(tx_tready_o, sample_req_i, "tx_tready_o");
    end
  end

  // ------------------------------
  // Host and keying drivers
  // ------------------------------

  task automatic write_reg(input logic [5:0] cmd_addr, input logic [31:0] cmd_data);
    @(posedge clk);
    cmd_i <= '{addr: cmd_addr, data: cmd_data, rqst: 1'b1};
    @(posedge clk);
    cmd_i <= '0;
  endtask

  // Returns in cycle 4 counted from the request
  task automatic write_freq(input logic [5:0] cmd_addr, input logic [31:0] cmd_data);
    int ack_cycle;
    @(posedge clk);
    cmd_i <= '{addr: cmd_addr, data: cmd_data, rqst: 1'b1};
    @(negedge clk);
    ack_cycle = 0;
    while (!cmd_ack_o && ack_cycle < 20) begin
      @(posedge clk);
      cmd_i.rqst <= 1'b0;
      @(negedge clk);
      ack_cycle++;
    end
    if (!cmd_ack_o) begin
      note_failure("cmd_ack_o never pulsed after a frequency write");
    end else if (ack_cycle != 3) begin
      note_failure($sformatf("cmd_ack_o came in cycle %0d, not cycle 3", ack_cycle));
    end
    @(posedge clk);
    cmd_i <= '0;
    @(negedge clk);
    check_bit(cmd_ack_o, 1'b0, "cmd_ack_o");
  endtask

  // Wait on tx_on_o or cw_on_o
  task automatic wait_keying(input bit cw, input logic level, input int limit,
                             output int cycles);
    cycles = 0;
    @(negedge clk);
    while ((cw ? cw_on_o : tx_on_o) !== level && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if ((cw ? cw_on_o : tx_on_o) !== level) begin
      note_failure($sformatf("%s did not go to %0b within %0d cycles",
                             cw ? "cw_on_o" : "tx_on_o", level, limit));
    end
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------

  initial begin
    logic [31:0]              d;
    logic [31:0]              d2;
    radio_cfg_pkg::phase_t    exp_phase;
    radio_cfg_pkg::phase_t    tx_before;
    radio_tx_pkg::iq_sample_t cw_top;
    radio_tx_pkg::iq_sample_t vna_iq;
    logic signed [15:0]       prev_i;
    int                       cyc;
    int                       pulses;
    bit                       ramp_bad;

    rst_all       = 1'b1;
    run_i         = 1'b1;
    ext_keydown_i = 1'b0;
    sample_req_i  = 1'b0;
    cmd_i         = '0;
    tx_stream_i   = '0;
    cw_top        = ref_cw_iq(radio_tx_pkg::CW_LEVEL_MAX);
    vna_iq.i      = radio_tx_pkg::VNA_TONE;
    vna_iq.q      = 16'sd0;
    repeat (16) @(posedge clk);
    rst_all <= 1'b0;

    // Simplex TX writes
    begin_test();
    for (int k = 0; k < 4; k++) begin
      d = draw_random();
      write_freq(radio_cfg_pkg::CMD_TX_FREQ, d);
      exp_phase = ref_phase_word(d);
      check_phase(tx_phase_o, exp_phase, "tx_phase_o");
      check_phase(rx0_phase_o, exp_phase, "rx0_phase_o");
    end
    end_test("frequency words");

    // Duplex on and then off again
    begin_test();
    write_reg(radio_cfg_pkg::CMD_CTRL, 32'h0000_0004);
    @(negedge clk);
    tx_before = tx_phase_o;
    d = draw_random();
    write_freq(radio_cfg_pkg::CMD_RX0_FREQ, d);
    check_phase(tx_phase_o, tx_before, "tx_phase_o");
    check_phase(rx0_phase_o, ref_phase_word(d), "rx0_phase_o");
    write_reg(radio_cfg_pkg::CMD_CTRL, 32'h0000_0000);
    d = draw_random();
    write_freq(radio_cfg_pkg::CMD_RX0_FREQ, d);
    check_phase(rx0_phase_o, tx_before, "rx0_phase_o");
    end_test("duplex rule");

    // Short latency and hang for keying
    begin_test();
    write_reg(radio_cfg_pkg::CMD_TX_TIMING, {19'd0, 5'(PTT_HANG_MS), 3'd0, 5'(LAT_MS)});
    d = draw_random();
    @(posedge clk);
    sample_req_i <= 1'b1;
    tx_stream_i  <= '{tdata: d, tvalid: 1'b1, tuser: 4'b1000};
    wait_keying(1'b0, 1'b1, WAIT_SHORT, cyc);
    check_bit(tx_tready_o, 1'b0, "tx_tready_o");
    // Prefill length in qmsec pulses
    pulses = 0;
    cyc    = 0;
    while (tx_tready_o == 1'b0 && cyc < WAIT_SHORT) begin
      if (qmsec_pulse_i) begin
        pulses++;
      end
      @(negedge clk);
      cyc++;
    end
    if (pulses < 4 * LAT_MS || pulses > 4 * LAT_MS + 1) begin
      note_failure($sformatf("tx_tready_o held low for %0d qmsec pulses, expected %0d",
                             pulses, 4 * LAT_MS));
    end
    // New data without a request is not latched
    d2 = draw_random();
    @(posedge clk);
    sample_req_i      <= 1'b0;
    tx_stream_i.tdata <= d2;
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_iq(tx_iq_o, ref_ptt_iq(d), "tx_iq_o");
    @(posedge clk);
    sample_req_i <= 1'b1;
    @(negedge clk);
    check_bit(tx_tready_o, 1'b1, "tx_tready_o");
    @(posedge clk);
    sample_req_i <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_iq(tx_iq_o, ref_ptt_iq(d2), "tx_iq_o");
    // PTT release and hang
    @(posedge clk);
    tx_stream_i <= '0;
    @(negedge clk);
    pulses = 0;
    cyc    = 0;
    while (tx_on_o && cyc < WAIT_SHORT) begin
      if (qmsec_pulse_i) begin
        pulses++;
      end
      @(negedge clk);
      cyc++;
    end
    if (tx_on_o) begin
      note_failure("tx_on_o stayed high after PTT release");
    end else if (pulses < 4 * PTT_HANG_MS || pulses > 4 * PTT_HANG_MS + 1) begin
      note_failure($sformatf("PTT hang lasted %0d qmsec pulses, expected %0d",
                             pulses, 4 * PTT_HANG_MS));
    end
    repeat (3) @(negedge clk);
    check_iq(tx_iq_o, '0, "tx_iq_o");
    end_test("PTT path");

    // CW ramp up by one level step per clock
    begin_test();
    write_reg(radio_cfg_pkg::CMD_CW_HANG, 32'(CW_HANG) << 16);
    @(posedge clk);
    ext_keydown_i <= 1'b1;
    wait_keying(1'b1, 1'b1, WAIT_SHORT, cyc);
    ramp_bad = 1'b0;
    prev_i   = 16'sd0;
    cyc      = 0;
    while (tx_iq_o.i !== cw_top.i && cyc < WAIT_RAMP) begin
      if (!ramp_bad && (tx_iq_o.i < prev_i || tx_iq_o.q !== 16'sd0)) begin
        ramp_bad = 1'b1;
        note_failure($sformatf("CW ramp not rising, I %h after %h", tx_iq_o.i, prev_i));
      end
      prev_i = tx_iq_o.i;
      @(negedge clk);
      cyc++;
    end
    if (cyc < LEVEL_MAX || cyc > LEVEL_MAX + 2) begin
      note_failure($sformatf("CW ramp took %0d cycles, expected %0d", cyc, LEVEL_MAX + 1));
    end
    repeat (4) @(negedge clk);
    check_iq(tx_iq_o, cw_top, "tx_iq_o");
    // Release through latency wait, ramp down and hang
    @(posedge clk);
    ext_keydown_i <= 1'b0;
    @(negedge clk);
    prev_i = tx_iq_o.i;
    cyc    = 0;
    while (cw_on_o && cyc < WAIT_RAMP) begin
      if (!ramp_bad && (tx_iq_o.i > prev_i || tx_iq_o.q !== 16'sd0)) begin
        ramp_bad = 1'b1;
        note_failure($sformatf("CW ramp not falling, I %h after %h", tx_iq_o.i, prev_i));
      end
      prev_i = tx_iq_o.i;
      @(negedge clk);
      cyc++;
    end
    if (cyc < LEVEL_MAX + (4 * LAT_MS - 1) * 8 + (4 * CW_HANG - 1) * 8 ||
        cyc > LEVEL_MAX + (4 * LAT_MS + 1) * 8 + (4 * CW_HANG + 1) * 8 + 4) begin
      note_failure($sformatf("cw_on_o fell %0d cycles after release", cyc));
    end
    check_bit(tx_on_o, 1'b0, "tx_on_o");
    check_iq(tx_iq_o, '0, "tx_iq_o");
    end_test("CW shaping");

    // VNA carrier overrides the CW level
    begin_test();
    write_reg(radio_cfg_pkg::CMD_VNA, 32'h0080_0000);
    @(posedge clk);
    ext_keydown_i <= 1'b1;
    wait_keying(1'b1, 1'b1, WAIT_SHORT, cyc);
    @(negedge clk);
    check_iq(tx_iq_o, vna_iq, "tx_iq_o");
    end_test("VNA tone");

    // Run drop while keyed
    begin_test();
    write_reg(radio_cfg_pkg::CMD_VNA, 32'h0000_0000);
    repeat (40) @(posedge clk);
    run_i <= 1'b0;
    wait_keying(1'b0, 1'b0, 20, cyc);
    if (cyc > 1) begin
      note_failure($sformatf("tx_on_o took %0d cycles to drop after run_i", cyc));
    end
    check_bit(cw_on_o, 1'b0, "cw_on_o");
    repeat (3) @(negedge clk);
    check_bit(tx_on_o, 1'b0, "tx_on_o");
    check_iq(tx_iq_o, '0, "tx_iq_o");
    @(posedge clk);
    ext_keydown_i <= 1'b0;
    run_i         <= 1'b1;
    repeat (4) @(negedge clk);
    check_bit(tx_on_o, 1'b0, "tx_on_o");
    end_test("run drop");

    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: radio_top.f
src/radio_cfg_pkg.sv
src/radio_tx_pkg.sv
src/radio_cmd_decoder.sv
src/tx_keyer.sv
src/tx_baseband.sv
src/radio_top.sv
tb/radio_top_tb.sv

// File: Bender.yml
package:
  name: radio_top

sources:
  - src/radio_cfg_pkg.sv
  - src/radio_tx_pkg.sv
  - src/radio_cmd_decoder.sv
  - src/tx_keyer.sv
  - src/tx_baseband.sv
  - src/radio_top.sv
  - target: simulation
    files:
      - tb/radio_top_tb.sv
